// ==== source/mips_pkg.sv ====
package mips_pkg;

	// =========================================================================
	// widths and memory depths
	// =========================================================================

	localparam int XLEN       = 32;
	localparam int REG_AW     = 5;
	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;

	// primary opcodes, instr[31:26].
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_J     = 6'h02;

	// r-type function codes, instr[5:0].
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLL = 6'h00;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_SLL = 3'd5
	} alu_op_e;

	// =========================================================================
	// pipeline registers
	// =========================================================================

	typedef struct packed {
		logic [XLEN-1:0] pc_next;
		logic [XLEN-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic              regwrite;
		logic              memtoreg;
		logic              memread;
		logic              memwrite;
		logic              isbranch;
		logic              isjump;
		logic              regdst;
		logic              alusrc;
		logic [XLEN-1:0]   pc_next;
		logic [XLEN-1:0]   pc_jump;
		logic [XLEN-1:0]   rs_data;
		logic [XLEN-1:0]   rt_data;
		logic [XLEN-1:0]   imm;
		logic [5:0]        opcode;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
	} id_ex_t;

	typedef struct packed {
		logic              regwrite;
		logic              memtoreg;
		logic              memread;
		logic              memwrite;
		logic              isbranch;
		logic              zero;
		logic              overflow;
		logic [XLEN-1:0]   pc_branch;
		logic [XLEN-1:0]   alu_res;
		logic [XLEN-1:0]   store_data;
		logic [REG_AW-1:0] wreg;
	} ex_mem_t;

	// mem/wb register, also the writeback bus.
	typedef struct packed {
		logic              regwrite;
		logic [REG_AW-1:0] wreg;
		logic [XLEN-1:0]   wdata;
	} retire_t;

	typedef struct packed {
		logic            we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
	} store_t;

endpackage

// ==== source/word_mem.sv ====
`timescale 1ns/1ps

module word_mem import mips_pkg::*; #(
	parameter int DEPTH = 64
) (
	input  logic            clk,
	input  logic [XLEN-1:0] addr,
	output logic [XLEN-1:0] rdata,
	input  logic            we,
	input  logic [XLEN-1:0] wdata
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [XLEN-1:0] mem [DEPTH];
	logic [AW-1:0]   idx;

	// byte address, word aligned.
	assign idx = addr[AW+1:2];

	assign rdata = mem[idx];

	// contents survive reset.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wdata;
		end
	end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [REG_AW-1:0] raddr_s,
	input  logic [REG_AW-1:0] raddr_t,
	output logic [XLEN-1:0]   rdata_s,
	output logic [XLEN-1:0]   rdata_t,
	input  retire_t           wb
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regwrite) begin
			regs[wb.wreg] <= wb.wdata;
		end
	end

	// r0 reads zero; a same-cycle write passes straight through.
	always_comb begin
		if (raddr_s == '0) rdata_s = '0;
		else if (wb.regwrite && wb.wreg == raddr_s) rdata_s = wb.wdata;
		else rdata_s = regs[raddr_s];

		if (raddr_t == '0) rdata_t = '0;
		else if (wb.regwrite && wb.wreg == raddr_t) rdata_t = wb.wdata;
		else rdata_t = regs[raddr_t];
	end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import mips_pkg::*; (
	input  alu_op_e         op,
	input  logic [XLEN-1:0] s,
	input  logic [XLEN-1:0] t,
	input  logic [4:0]      shamt,
	output logic [XLEN-1:0] res,
	output logic            zero,
	output logic            overflow
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;

	assign sum  = s + t;
	assign diff = s - t;

	always_comb begin
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				res      = sum;
				overflow = (s[XLEN-1] == t[XLEN-1]) && (sum[XLEN-1] != s[XLEN-1]);
			end
			ALU_SUB: begin
				res      = diff;
				overflow = (s[XLEN-1] != t[XLEN-1]) && (diff[XLEN-1] != s[XLEN-1]);
			end
			ALU_AND: res = s & t;
			ALU_OR:  res = s | t;
			ALU_SLT: res = {{(XLEN-1){1'b0}}, $signed(s) < $signed(t)};
			ALU_SLL: res = t << shamt;
			default: res = '0;
		endcase
	end

	assign zero = (res == '0);

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            jump_taken,
	input  logic [XLEN-1:0] jump_target,
	input  logic            branch_taken,
	input  logic [XLEN-1:0] branch_target,
	input  logic            prog_we,
	input  logic [XLEN-1:0] prog_addr,
	input  logic [XLEN-1:0] prog_data,
	output if_id_t          if_id
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_in;
	logic [XLEN-1:0] imem_addr;
	logic [XLEN-1:0] instr;

	assign pc_plus4 = pc + XLEN'(4);

	// branch from memory is older than a jump in execute.
	always_comb begin
		if (branch_taken) pc_in = branch_target;
		else if (jump_taken) pc_in = jump_target;
		else pc_in = pc_plus4;
	end

	// program loading steals the port.
	assign imem_addr = prog_we ? prog_addr : pc;

	word_mem #(.DEPTH(IMEM_DEPTH)) u_imem (
		.clk   (clk),
		.addr  (imem_addr),
		.rdata (instr),
		.we    (prog_we),
		.wdata (prog_data)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc    <= '0;
			if_id <= '0;
		end else begin
			pc <= pc_in;
			if (branch_taken || jump_taken) if_id <= '0;
			else if_id <= '{pc_next: pc_plus4, instr: instr};
		end
	end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  if_id_t if_id,
	input  retire_t wb,
	input  logic   jump_taken,
	input  logic   branch_taken,
	output id_ex_t id_ex
);

	logic [5:0]        opcode;
	logic [REG_AW-1:0] rs;
	logic [REG_AW-1:0] rt;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   rs_data;
	logic [XLEN-1:0]   rt_data;
	id_ex_t            id_next;

	assign opcode = if_id.instr[31:26];
	assign rs     = if_id.instr[25:21];
	assign rt     = if_id.instr[20:16];
	assign rd     = if_id.instr[15:11];

	reg_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.raddr_s (rs),
		.raddr_t (rt),
		.rdata_s (rs_data),
		.rdata_t (rt_data),
		.wb      (wb)
	);

	// =========================================================================
	// control decode
	// =========================================================================

	always_comb begin
		id_next = '0;
		case (opcode)
			OP_RTYPE: begin
				id_next.regwrite = 1'b1;
				id_next.regdst   = 1'b1;
			end
			OP_ADDI: begin
				id_next.regwrite = 1'b1;
				id_next.alusrc   = 1'b1;
			end
			OP_LW: begin
				id_next.regwrite = 1'b1;
				id_next.memtoreg = 1'b1;
				id_next.memread  = 1'b1;
				id_next.alusrc   = 1'b1;
			end
			OP_SW: begin
				id_next.memwrite = 1'b1;
				id_next.alusrc   = 1'b1;
			end
			OP_BEQ: id_next.isbranch = 1'b1;
			OP_J:   id_next.isjump   = 1'b1;
			default: ;
		endcase

		// writes to r0 are dropped, so the zero word is a nop.
		if ((id_next.regdst ? rd : rt) == '0) id_next.regwrite = 1'b0;

		id_next.pc_next = if_id.pc_next;
		id_next.pc_jump = {if_id.pc_next[31:28], if_id.instr[25:0], 2'b00};
		id_next.rs_data = rs_data;
		id_next.rt_data = rt_data;
		id_next.imm     = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
		id_next.opcode  = opcode;
		id_next.rs      = rs;
		id_next.rt      = rt;
		id_next.rd      = rd;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) id_ex <= '0;
		else if (jump_taken || branch_taken) id_ex <= '0;
		else id_ex <= id_next;
	end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  id_ex_t          id_ex,
	input  ex_mem_t         fwd_mem,
	input  retire_t         wb,
	input  logic            branch_taken,
	output ex_mem_t         ex_mem,
	output logic            jump_taken,
	output logic [XLEN-1:0] jump_target
);

	alu_op_e         alu_op;
	logic [XLEN-1:0] s_fwd;
	logic [XLEN-1:0] t_fwd;
	logic [XLEN-1:0] alu_t;
	logic [XLEN-1:0] alu_res;
	logic            alu_zero;
	logic            alu_ovf;
	ex_mem_t         ex_next;

	// newest producer wins; r0 never forwards.
	function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_AW-1:0] r,
			input logic [XLEN-1:0] dflt, input ex_mem_t m, input retire_t w);
		if (m.regwrite && m.wreg != '0 && m.wreg == r) return m.alu_res;
		if (w.regwrite && w.wreg != '0 && w.wreg == r) return w.wdata;
		return dflt;
	endfunction

	// alu control.
	always_comb begin
		alu_op = ALU_ADD;
		case (id_ex.opcode)
			OP_RTYPE: begin
				case (id_ex.imm[5:0])
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLL:  alu_op = ALU_SLL;
					default: alu_op = ALU_ADD;
				endcase
			end
			OP_BEQ:  alu_op = ALU_SUB;
			default: alu_op = ALU_ADD;
		endcase
	end

	assign s_fwd = fwd_sel(id_ex.rs, id_ex.rs_data, fwd_mem, wb);
	assign t_fwd = fwd_sel(id_ex.rt, id_ex.rt_data, fwd_mem, wb);
	assign alu_t = id_ex.alusrc ? id_ex.imm : t_fwd;

	alu u_alu (
		.op       (alu_op),
		.s        (s_fwd),
		.t        (alu_t),
		.shamt    (id_ex.imm[10:6]),
		.res      (alu_res),
		.zero     (alu_zero),
		.overflow (alu_ovf)
	);

	assign jump_taken  = id_ex.isjump & ~branch_taken;
	assign jump_target = id_ex.pc_jump;

	assign ex_next = '{
		regwrite:   id_ex.regwrite,
		memtoreg:   id_ex.memtoreg,
		memread:    id_ex.memread,
		memwrite:   id_ex.memwrite,
		isbranch:   id_ex.isbranch,
		zero:       alu_zero,
		overflow:   alu_ovf,
		pc_branch:  id_ex.pc_next + (id_ex.imm << 2),
		alu_res:    alu_res,
		store_data: t_fwd,
		wreg:       id_ex.regdst ? id_ex.rd : id_ex.rt
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) ex_mem <= '0;
		else if (branch_taken) ex_mem <= '0;
		else ex_mem <= ex_next;
	end

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  ex_mem_t         ex_mem,
	output logic            branch_taken,
	output logic [XLEN-1:0] branch_target,
	output store_t          store,
	output retire_t         wb
);

	logic [XLEN-1:0] load_data;
	logic            load_sel;

	// beq resolves here, on the subtract result.
	assign branch_taken  = ex_mem.isbranch & ex_mem.zero;
	assign branch_target = ex_mem.pc_branch;

	assign store = '{
		we:   ex_mem.memwrite,
		addr: ex_mem.alu_res,
		data: ex_mem.store_data
	};

	word_mem #(.DEPTH(DMEM_DEPTH)) u_dmem (
		.clk   (clk),
		.addr  (store.addr),
		.rdata (load_data),
		.we    (store.we),
		.wdata (store.data)
	);

	assign load_sel = ex_mem.memread & ex_mem.memtoreg;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb.regwrite <= ex_mem.regwrite;
			wb.wreg     <= ex_mem.wreg;
			wb.wdata    <= load_sel ? load_data : ex_mem.alu_res;
		end
	end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            prog_we,
	input  logic [XLEN-1:0] prog_addr,
	input  logic [XLEN-1:0] prog_data,
	output retire_t         retire,
	output store_t          store
);

	if_id_t          if_id;
	id_ex_t          id_ex;
	ex_mem_t         ex_mem;
	logic            jump_taken;
	logic [XLEN-1:0] jump_target;
	logic            branch_taken;
	logic [XLEN-1:0] branch_target;

	fetch_stage u_fetch (
		.clk           (clk),
		.rst_n         (rst_n),
		.jump_taken    (jump_taken),
		.jump_target   (jump_target),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.prog_we       (prog_we),
		.prog_addr     (prog_addr),
		.prog_data     (prog_data),
		.if_id         (if_id)
	);

	// retire doubles as the writeback bus.
	decode_stage u_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.if_id        (if_id),
		.wb           (retire),
		.jump_taken   (jump_taken),
		.branch_taken (branch_taken),
		.id_ex        (id_ex)
	);

	execute_stage u_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.id_ex        (id_ex),
		.fwd_mem      (ex_mem),
		.wb           (retire),
		.branch_taken (branch_taken),
		.ex_mem       (ex_mem),
		.jump_taken   (jump_taken),
		.jump_target  (jump_target)
	);

	memory_stage u_memory (
		.clk           (clk),
		.rst_n         (rst_n),
		.ex_mem        (ex_mem),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.store         (store),
		.wb            (retire)
	);

endmodule

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import mips_pkg::*; ();

	localparam int NTESTS       = 6;
	localparam int MAX_WORDS    = 16;
	localparam int MAX_EVENTS   = 12;
	localparam int RESET_CYCLES = 4;
	localparam int PAD_MIN      = 12;
	localparam int PAD_RAND     = 8;
	localparam int DRAIN        = 6;
	localparam int SEED         = 39643;

	logic            clk;
	logic            rst_n;
	logic            prog_we;
	logic [XLEN-1:0] prog_addr;
	logic [XLEN-1:0] prog_data;
	retire_t         retire;
	store_t          store;

	// =========================================================================
	// test table
	// =========================================================================

	string       test_name [NTESTS];
	int          base_word [NTESTS];
	int          prog_len  [NTESTS];
	logic [31:0] prog_mem  [NTESTS][MAX_WORDS];
	int          n_ret     [NTESTS];
	logic [31:0] ret_reg   [NTESTS][MAX_EVENTS];
	logic [31:0] ret_val   [NTESTS][MAX_EVENTS];
	int          n_st      [NTESTS];
	logic [31:0] st_addr   [NTESTS][MAX_EVENTS];
	logic [31:0] st_data   [NTESTS][MAX_EVENTS];

	int   cur_build    = -1;
	int   cur_test     = 0;
	int   ret_idx      = 0;
	int   st_idx       = 0;
	logic monitor_on   = 1'b0;
	logic tables_ready = 1'b0;

	cpu_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.retire    (retire),
		.store     (store)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// instruction assembly.
	function automatic logic [31:0] rtype_word(input logic [5:0] fn, input int rd,
			input int rs, input int rt, input int sh);
		rtype_word = {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt,
			input int rs, input int imm);
		itype_word = {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] jump_word(input int index);
		jump_word = {OP_J, index[25:0]};
	endfunction

	task automatic new_test(input string name, input int base);
		cur_build++;
		test_name[cur_build] = name;
		base_word[cur_build] = base;
		prog_len[cur_build]  = 0;
		n_ret[cur_build]     = 0;
		n_st[cur_build]      = 0;
	endtask

	task automatic add_word(input logic [31:0] w);
		prog_mem[cur_build][prog_len[cur_build]] = w;
		prog_len[cur_build]++;
	endtask

	task automatic expect_retire(input int r, input logic [31:0] v);
		ret_reg[cur_build][n_ret[cur_build]] = r;
		ret_val[cur_build][n_ret[cur_build]] = v;
		n_ret[cur_build]++;
	endtask

	task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
		st_addr[cur_build][n_st[cur_build]] = a;
		st_data[cur_build][n_st[cur_build]] = d;
		n_st[cur_build]++;
	endtask

	task automatic build_tables();
		// sources one to three instructions back use mem, wb and the register bypass.
		new_test("rtype_fwd", 0);
		add_word(itype_word(OP_ADDI, 1, 0, 5));
		add_word(itype_word(OP_ADDI, 2, 0, 3));
		add_word(rtype_word(FN_ADD, 3, 1, 2, 0));
		add_word(rtype_word(FN_SUB, 4, 3, 1, 0));
		add_word(rtype_word(FN_AND, 5, 4, 3, 0));
		add_word(rtype_word(FN_OR, 6, 4, 3, 0));
		add_word(rtype_word(FN_SLT, 7, 4, 3, 0));
		add_word(rtype_word(FN_SLT, 8, 3, 4, 0));
		add_word(rtype_word(FN_SUB, 9, 2, 3, 0));
		add_word(rtype_word(FN_SLT, 10, 9, 2, 0));
		expect_retire(1, 32'h5);
		expect_retire(2, 32'h3);
		expect_retire(3, 32'h8);
		expect_retire(4, 32'h3);
		expect_retire(5, 32'h0);
		expect_retire(6, 32'hb);
		expect_retire(7, 32'h1);
		expect_retire(8, 32'h0);
		expect_retire(9, 32'hffff_fffb);
		expect_retire(10, 32'h1);

		new_test("addi_sll", 0);
		add_word(itype_word(OP_ADDI, 1, 0, -1));
		add_word(itype_word(OP_ADDI, 2, 1, -100));
		add_word(itype_word(OP_ADDI, 3, 0, 32'h7ff0));
		add_word(itype_word(OP_ADDI, 4, 0, 32'h8000));
		add_word(rtype_word(FN_SLL, 5, 0, 3, 4));
		add_word(rtype_word(FN_SLL, 6, 0, 1, 31));
		add_word(rtype_word(FN_SLL, 7, 0, 2, 0));
		expect_retire(1, 32'hffff_ffff);
		expect_retire(2, 32'hffff_ff9b);
		expect_retire(3, 32'h0000_7ff0);
		expect_retire(4, 32'hffff_8000);
		expect_retire(5, 32'h0007_ff00);
		expect_retire(6, 32'h8000_0000);
		expect_retire(7, 32'hffff_ff9b);

		// every load is followed by a nop before its consumer.
		new_test("store_load", 0);
		add_word(itype_word(OP_ADDI, 1, 0, 32'h40));
		add_word(itype_word(OP_ADDI, 2, 0, 32'h1234));
		add_word(itype_word(OP_SW, 2, 1, 8));
		add_word(itype_word(OP_ADDI, 3, 0, -7));
		add_word(itype_word(OP_SW, 3, 1, -4));
		add_word(itype_word(OP_LW, 4, 1, 8));
		add_word(32'h0);
		add_word(rtype_word(FN_ADD, 5, 4, 3, 0));
		add_word(itype_word(OP_LW, 6, 1, -4));
		add_word(32'h0);
		add_word(itype_word(OP_SW, 6, 1, 0));
		expect_retire(1, 32'h40);
		expect_retire(2, 32'h1234);
		expect_retire(3, 32'hffff_fff9);
		expect_retire(4, 32'h1234);
		expect_retire(5, 32'h122d);
		expect_retire(6, 32'hffff_fff9);
		expect_store(32'h48, 32'h1234);
		expect_store(32'h3c, 32'hffff_fff9);
		expect_store(32'h40, 32'hffff_fff9);

		// the taken beq skips words 3 to 6 and the second beq falls through.
		new_test("beq", 0);
		add_word(itype_word(OP_ADDI, 1, 0, 7));
		add_word(itype_word(OP_ADDI, 2, 0, 7));
		add_word(itype_word(OP_BEQ, 2, 1, 4));
		add_word(itype_word(OP_ADDI, 3, 0, 1));
		add_word(itype_word(OP_ADDI, 4, 0, 2));
		add_word(itype_word(OP_ADDI, 5, 0, 3));
		add_word(itype_word(OP_ADDI, 6, 0, 4));
		add_word(itype_word(OP_ADDI, 9, 0, 9));
		add_word(itype_word(OP_BEQ, 3, 1, 2));
		add_word(itype_word(OP_ADDI, 7, 0, 5));
		add_word(itype_word(OP_ADDI, 8, 0, 6));
		expect_retire(1, 32'h7);
		expect_retire(2, 32'h7);
		expect_retire(9, 32'h9);
		expect_retire(7, 32'h5);
		expect_retire(8, 32'h6);

		new_test("jump", 0);
		add_word(itype_word(OP_ADDI, 1, 0, 1));
		add_word(jump_word(5));
		add_word(itype_word(OP_ADDI, 2, 0, 2));
		add_word(itype_word(OP_ADDI, 3, 0, 3));
		add_word(itype_word(OP_ADDI, 4, 0, 4));
		add_word(itype_word(OP_ADDI, 5, 1, 10));
		add_word(rtype_word(FN_ADD, 6, 5, 1, 0));
		expect_retire(1, 32'h1);
		expect_retire(5, 32'hb);
		expect_retire(6, 32'hc);

		// nothing may retire before r1 after the leading nops.
		new_test("r0_writes", 6);
		add_word(itype_word(OP_ADDI, 1, 0, 9));
		add_word(itype_word(OP_ADDI, 0, 1, 5));
		add_word(rtype_word(FN_ADD, 0, 1, 1, 0));
		add_word(rtype_word(FN_ADD, 2, 0, 1, 0));
		add_word(rtype_word(FN_OR, 3, 0, 0, 0));
		add_word(rtype_word(FN_SLL, 0, 0, 1, 2));
		add_word(itype_word(OP_ADDI, 4, 0, 0));
		expect_retire(1, 32'h9);
		expect_retire(2, 32'h9);
		expect_retire(3, 32'h0);
		expect_retire(4, 32'h0);
	endtask

	// =========================================================================
	// checking
	// =========================================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// retire and store events in program order.
	always @(negedge clk) begin
		if (monitor_on && retire.regwrite) begin
			if (ret_idx >= n_ret[cur_test]) begin
				abort_run($sformatf("test %s retired an unexpected write to r%0d",
					test_name[cur_test], retire.wreg));
			end else begin
				check_value($sformatf("%s retire %0d reg", test_name[cur_test], ret_idx),
					ret_reg[cur_test][ret_idx], {27'b0, retire.wreg});
				check_value($sformatf("%s retire %0d data", test_name[cur_test], ret_idx),
					ret_val[cur_test][ret_idx], retire.wdata);
				ret_idx++;
			end
		end
		if (monitor_on && store.we) begin
			if (st_idx >= n_st[cur_test]) begin
				abort_run($sformatf("test %s made an unexpected store to address %h",
					test_name[cur_test], store.addr));
			end else begin
				check_value($sformatf("%s store %0d addr", test_name[cur_test], st_idx),
					st_addr[cur_test][st_idx], store.addr);
				check_value($sformatf("%s store %0d data", test_name[cur_test], st_idx),
					st_data[cur_test][st_idx], store.data);
				st_idx++;
			end
		end
	end

	// =========================================================================
	// running the tests
	// =========================================================================

	// unused words hold addi r0, r0 with the word index as immediate.
	function automatic logic [31:0] program_word(input int t, input int w);
		if (w < base_word[t] || w >= base_word[t] + prog_len[t]) return itype_word(OP_ADDI, 0, 0, w);
		return prog_mem[t][w - base_word[t]];
	endfunction

	task automatic run_test(input int t);
		int pad;
		int nwords;
		// random-length nop run after the program hides older code.
		pad = PAD_MIN + int'($urandom_range(PAD_RAND));
		nwords = base_word[t] + prog_len[t] + pad;
		@(posedge clk);
		rst_n <= 1'b0;
		cur_test = t;
		ret_idx  = 0;
		st_idx   = 0;
		for (int w = 0; w < nwords; w++) begin
			@(posedge clk);
			prog_we   <= 1'b1;
			prog_addr <= w * 4;
			prog_data <= program_word(t, w);
		end
		@(posedge clk);
		prog_we <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		monitor_on = 1'b1;
		while (ret_idx < n_ret[t] || st_idx < n_st[t]) @(posedge clk);
		// catch late events from flushed instructions.
		repeat (DRAIN) @(posedge clk);
		monitor_on = 1'b0;
	endtask

	initial begin
		int limit;
		wait (tables_ready);
		limit = 0;
		for (int t = 0; t < NTESTS; t++) begin
			limit += base_word[t] + prog_len[t] + PAD_MIN + PAD_RAND + 2 + RESET_CYCLES;
			limit += 2 * (base_word[t] + prog_len[t]) + 20 + DRAIN;
		end
		repeat (limit) @(posedge clk);
		abort_run("timeout: the expected retires and stores did not arrive in time");
	end

	initial begin
		rst_n     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		void'($urandom(SEED));
		build_tables();
		tables_ready = 1'b1;
		for (int t = 0; t < NTESTS; t++) begin
			run_test(t);
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== tb.f ====
source/mips_pkg.sv
source/word_mem.sv
source/reg_file.sv
source/alu.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
tb/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_cpu
RTL_TOP   := cpu_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx '>>> PASS' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
